// File: verification/resize_testdata.txt
// columns: pixel seed (0 keeps the running sequence), max output ack delay, source pixel count
// all fields hex, one frame per line, the first pixel of each frame carries sof
07a4bde3 0 50
00000000 3 50
00000000 7 25
5a5a1234 2 50
00000000 f 0f
00000000 1 50
9e3779b9 5 37
00000000 0 01
00000000 a 50
00000000 4 17
1d872b41 6 50
00000000 f 2d
00000000 2 0b
00000000 8 50
00000000 0 00

// File: src.f
+incdir+logic
logic/resize_pkg.sv
logic/resize_col_sampler.sv
logic/resize_row_sampler.sv
logic/resize_pixel_gate.sv
logic/resize_top.sv
verification/resize_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := resize_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/resize_tb.sv
`timescale 1ns/1ps
`include "resize_params.svh"

module resize_tb import resize_pkg::*;
();

	localparam int X_RATIO = ((`RESIZE_SRC_W << `RESIZE_RATIO_FRAC) / `RESIZE_DST_W) + 1;
	localparam int Y_RATIO = ((`RESIZE_SRC_H << `RESIZE_RATIO_FRAC) / `RESIZE_DST_H) + 1;
	localparam int TIMEOUT = 400;
	localparam int MAX_FRAMES = 32;

	logic     i_clk_os = 1'b0;
	logic     i_rst;
	logic     i_in_req;
	pix_in_t  i_in;
	logic     o_in_ack;
	logic     o_out_req;
	pix_out_t o_out;
	logic     i_out_ack;

	logic [31:0]              testdata [0:3*MAX_FRAMES-1];
	logic [31:0]              lfsr;
	logic [`RESIZE_PIX_W-1:0] pix_vals [0:`RESIZE_SRC_W*`RESIZE_SRC_H-1];
	pix_out_t                 exp_q [$];

	resize_top resize_top_i (.*);

	initial
	begin
		forever #2 i_clk_os = ~i_clk_os;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_out(input string name, input pix_out_t got, input pix_out_t exp);
		if (got !== exp)
			abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int b = 0; b < n; b++)
		begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// target index whose (k * ratio) >> frac lands on x or -1 for a skipped x
	function automatic int sel_index(input int x, input int ratio, input int dst);
		for (int k = 0; k < dst; k++)
			if (((k * ratio) >> `RESIZE_RATIO_FRAC) == x)
				return k;
		return -1;
	endfunction

	// samples on falling edges and watches the input ack during an output release
	task automatic wait_for(input bit on_out, input logic level, input string what);
		int n;
		n = 0;
		@(negedge i_clk_os);
		while ((on_out ? o_out_req : o_in_ack) !== level)
		begin
			if (on_out && !level)
				check_flag("o_in_ack", o_in_ack, 1'b0);
			n++;
			if (n > TIMEOUT)
				abort_run($sformatf("timeout waiting for %s, handshake hung", what));
			@(negedge i_clk_os);
		end
	endtask

	// pixel values plus the expected resized output of one frame
	task automatic build_frame(input int count);
		logic [31:0] r;
		int          kc;
		int          kr;
		pix_out_t    p;
		for (int i = 0; i < count; i++)
		begin
			r           = lfsr_bits(`RESIZE_PIX_W);
			pix_vals[i] = r[`RESIZE_PIX_W-1:0];
			kc = sel_index(i % `RESIZE_SRC_W, X_RATIO, `RESIZE_DST_W);
			kr = sel_index((i / `RESIZE_SRC_W) % `RESIZE_SRC_H, Y_RATIO, `RESIZE_DST_H);
			if (kc >= 0 && kr >= 0)
			begin
				p.value = pix_vals[i];
				p.sof   = (kc == 0 && kr == 0);
				p.eol   = (kc == `RESIZE_DST_W - 1);
				exp_q.push_back(p);
			end
		end
	endtask

	task automatic send_frame(input int count);
		for (int i = 0; i < count; i++)
		begin
			i_in.value = pix_vals[i];
			i_in.sof   = (i == 0);
			i_in_req   = 1'b1;
			wait_for(1'b0, 1'b1, "input ack rise");
			i_in_req = 1'b0;
			wait_for(1'b0, 1'b0, "input ack fall");
		end
	endtask

	task automatic receive_frame(input int max_delay);
		pix_out_t held;
		int       delay;
		while (exp_q.size() > 0)
		begin
			wait_for(1'b1, 1'b1, "output req rise");
			held = o_out;
			check_out("o_out", held, exp_q.pop_front());
			delay = int'(lfsr_bits(4)) % (max_delay + 1);
			// sink holds off while the pixel stays put and the source stalls
			repeat (delay)
			begin
				@(negedge i_clk_os);
				check_flag("o_out_req", o_out_req, 1'b1);
				check_out("o_out", o_out, held);
				check_flag("o_in_ack", o_in_ack, 1'b0);
			end
			i_out_ack = 1'b1;
			wait_for(1'b1, 1'b0, "output req fall");
			i_out_ack = 1'b0;
		end
	endtask

	initial
	begin
		int count;
		lfsr      = 32'h07a4_bde3;
		i_rst     = 1'b1;
		i_in_req  = 1'b0;
		i_in      = '0;
		i_out_ack = 1'b0;
		$readmemh("verification/resize_testdata.txt", testdata);
		repeat (4) @(negedge i_clk_os);
		i_rst = 1'b0;
		// both channels quiet until the source asks
		repeat (6)
		begin
			@(negedge i_clk_os);
			check_flag("o_in_ack", o_in_ack, 1'b0);
			check_flag("o_out_req", o_out_req, 1'b0);
		end
		for (int f = 0; f < MAX_FRAMES; f++)
		begin
			if (testdata[3*f+2] == 32'h0 || $isunknown(testdata[3*f+2]))
				break;
			if (testdata[3*f] != 32'h0)
				lfsr = testdata[3*f];
			count = int'(testdata[3*f+2]);
			if (count > `RESIZE_SRC_W * `RESIZE_SRC_H)
				abort_run("test data frame is longer than a source frame");
			build_frame(count);
			fork
				send_frame(count);
				receive_frame(int'(testdata[3*f+1]));
			join
		end
		// nothing left over after the last frame
		repeat (8)
		begin
			@(negedge i_clk_os);
			check_flag("o_out_req", o_out_req, 1'b0);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: logic/resize_top.sv
`timescale 1ns/1ps

module resize_top import resize_pkg::*;
(
	input  logic     i_clk_os,
	input  logic     i_rst,
	input  logic     i_in_req,
	input  pix_in_t  i_in,
	output logic     o_in_ack,
	output logic     o_out_req,
	output pix_out_t o_out,
	input  logic     i_out_ack
);

	logic step;
	logic frame_start;
	logic col_hit;
	logic col_last;
	logic line_end;
	logic row_hit;
	logic row_last;

	resize_col_sampler resize_col_sampler_i (
		.i_clk_os      (i_clk_os),
		.i_rst         (i_rst),
		.i_step        (step),
		.i_frame_start (frame_start),
		.o_hit         (col_hit),
		.o_last        (col_last),
		.o_line_end    (line_end)
	);

	// rows advance on the step that closes a source line
	resize_row_sampler resize_row_sampler_i (
		.i_clk_os      (i_clk_os),
		.i_rst         (i_rst),
		.i_step        (step),
		.i_frame_start (frame_start),
		.i_line_end    (line_end),
		.o_hit         (row_hit),
		.o_last        (row_last)
	);

	resize_pixel_gate resize_pixel_gate_i (
		.i_clk_os      (i_clk_os),
		.i_rst         (i_rst),
		.i_in_req      (i_in_req),
		.i_in          (i_in),
		.o_in_ack      (o_in_ack),
		.o_out_req     (o_out_req),
		.o_out         (o_out),
		.i_out_ack     (i_out_ack),
		.o_step        (step),
		.o_frame_start (frame_start),
		.i_col_hit     (col_hit),
		.i_col_last    (col_last),
		.i_row_hit     (row_hit),
		.i_row_last    (row_last)
	);

endmodule

// File: logic/resize_pixel_gate.sv
`timescale 1ns/1ps
`include "resize_params.svh"

module resize_pixel_gate import resize_pkg::*;
(
	input  logic     i_clk_os,
	input  logic     i_rst,
	input  logic     i_in_req,
	input  pix_in_t  i_in,
	output logic     o_in_ack,
	output logic     o_out_req,
	output pix_out_t o_out,
	input  logic     i_out_ack,
	output logic     o_step,
	output logic     o_frame_start,
	input  logic     i_col_hit,
	input  logic     i_col_last,
	input  logic     i_row_hit,
	input  logic     i_row_last
);

	gate_state_t state;
	logic        step_q;
	logic        frame_start_q;
	logic        first_pend;

	logic keep;
	logic eff_col_last;
	logic eff_row_last;

	// with sof the pixel sits at target (0,0), which is always selected
	assign keep         = frame_start_q | (i_col_hit & i_row_hit);
	assign eff_col_last = frame_start_q ? (`RESIZE_DST_W == 1) : i_col_last;
	assign eff_row_last = frame_start_q ? (`RESIZE_DST_H == 1) : i_row_last;

	always_ff @(posedge i_clk_os)
	begin
		if (i_rst)
		begin
			state         <= GATE_IDLE;
			step_q        <= 1'b0;
			frame_start_q <= 1'b0;
			first_pend    <= 1'b1;
			o_in_ack      <= 1'b0;
			o_out_req     <= 1'b0;
		end
		else
		begin
			step_q <= 1'b0;
			case (state)
				GATE_IDLE:
				begin
					if (step_q)
					begin
						// samplers still show the accepted pixel this cycle
						if (keep)
						begin
							o_out_req  <= 1'b1;
							first_pend <= eff_col_last & eff_row_last;
							state      <= GATE_OUT_REQ;
						end
						else
						begin
							o_in_ack <= 1'b1;
							state    <= GATE_IN_ACK;
						end
					end
					else if (i_in_req)
					begin
						step_q        <= 1'b1;
						frame_start_q <= i_in.sof;
					end
				end
				GATE_OUT_REQ:
				begin
					if (i_out_ack)
					begin
						o_out_req <= 1'b0;
						state     <= GATE_OUT_REL;
					end
				end
				GATE_OUT_REL:
				begin
					// source stays stalled until the sink has released
					if (!i_out_ack)
					begin
						o_in_ack <= 1'b1;
						state    <= GATE_IN_ACK;
					end
				end
				GATE_IN_ACK:
				begin
					if (!i_in_req)
					begin
						o_in_ack <= 1'b0;
						state    <= GATE_IDLE;
					end
				end
				default:
				begin
					state <= GATE_IDLE;
				end
			endcase
		end
	end

	// output pixel, loaded only when o_out_req goes high
	always_ff @(posedge i_clk_os)
	begin
		if (state == GATE_IDLE && step_q && keep)
		begin
			o_out.value <= i_in.value;
			o_out.sof   <= frame_start_q | first_pend;
			o_out.eol   <= eff_col_last;
		end
	end

	assign o_step        = step_q;
	assign o_frame_start = frame_start_q;

endmodule

// File: logic/resize_row_sampler.sv
`timescale 1ns/1ps
`include "resize_params.svh"

module resize_row_sampler import resize_pkg::*;
(
	input  logic i_clk_os,
	input  logic i_rst,
	input  logic i_step,
	input  logic i_frame_start,
	input  logic i_line_end,
	output logic o_hit,
	output logic o_last
);

	coord_t src_row;
	coord_t tgt_idx;
	coord_t sel_row;

	coord_t      cur_row;
	coord_t      cur_tgt;
	coord_t      cur_sel;
	coord_t      nxt_tgt;
	logic [31:0] sel_prod;
	logic        cur_hit;
	logic        cur_le;
	logic        cur_end;

	// on a frame start the column sampler's line end is stale
	assign cur_row = i_frame_start ? '0 : src_row;
	assign cur_tgt = i_frame_start ? '0 : tgt_idx;
	assign cur_sel = i_frame_start ? '0 : sel_row;
	assign cur_le  = i_frame_start ? (`RESIZE_SRC_W == 1) : i_line_end;
	assign cur_hit = (cur_row == cur_sel);
	assign cur_end = (cur_row == coord_t'(`RESIZE_SRC_H - 1));

	assign nxt_tgt  = cur_tgt + 1'b1;
	assign sel_prod = 32'(nxt_tgt) * 32'(`RESIZE_Y_RATIO);

	always_ff @(posedge i_clk_os)
	begin
		if (i_rst)
		begin
			src_row <= '0;
			tgt_idx <= '0;
			sel_row <= '0;
		end
		else if (i_step)
		begin
			if (!cur_le)
			begin
				// mid line, only a frame start changes anything
				src_row <= cur_row;
				tgt_idx <= cur_tgt;
				sel_row <= cur_sel;
			end
			else if (cur_end)
			begin
				src_row <= '0;
				tgt_idx <= '0;
				sel_row <= '0;
			end
			else
			begin
				src_row <= cur_row + 1'b1;
				tgt_idx <= cur_hit ? nxt_tgt : cur_tgt;
				sel_row <= cur_hit ? coord_t'(sel_prod >> `RESIZE_RATIO_FRAC) : cur_sel;
			end
		end
	end

	// held for a whole source line
	assign o_hit  = (src_row == sel_row);
	assign o_last = (tgt_idx == coord_t'(`RESIZE_DST_H - 1));

endmodule

// File: logic/resize_col_sampler.sv
`timescale 1ns/1ps
`include "resize_params.svh"

module resize_col_sampler import resize_pkg::*;
(
	input  logic i_clk_os,
	input  logic i_rst,
	input  logic i_step,
	input  logic i_frame_start,
	output logic o_hit,
	output logic o_last,
	output logic o_line_end
);

	coord_t src_col;
	coord_t tgt_idx;
	coord_t sel_col;

	coord_t      cur_col;
	coord_t      cur_tgt;
	coord_t      cur_sel;
	coord_t      nxt_tgt;
	logic [31:0] sel_prod;
	logic        cur_hit;
	logic        cur_end;

	// a frame start puts the current pixel at column 0, target 0
	assign cur_col = i_frame_start ? '0 : src_col;
	assign cur_tgt = i_frame_start ? '0 : tgt_idx;
	assign cur_sel = i_frame_start ? '0 : sel_col;
	assign cur_hit = (cur_col == cur_sel);
	assign cur_end = (cur_col == coord_t'(`RESIZE_SRC_W - 1));

	// next selected column is (k * ratio) >> frac
	assign nxt_tgt  = cur_tgt + 1'b1;
	assign sel_prod = 32'(nxt_tgt) * 32'(`RESIZE_X_RATIO);

	always_ff @(posedge i_clk_os)
	begin
		if (i_rst)
		begin
			src_col <= '0;
			tgt_idx <= '0;
			sel_col <= '0;
		end
		else if (i_step)
		begin
			if (cur_end)
			begin
				// next source line starts over at target 0
				src_col <= '0;
				tgt_idx <= '0;
				sel_col <= '0;
			end
			else
			begin
				src_col <= cur_col + 1'b1;
				tgt_idx <= cur_hit ? nxt_tgt : cur_tgt;
				sel_col <= cur_hit ? coord_t'(sel_prod >> `RESIZE_RATIO_FRAC) : cur_sel;
			end
		end
	end

	assign o_hit      = (src_col == sel_col);
	assign o_last     = (tgt_idx == coord_t'(`RESIZE_DST_W - 1));
	assign o_line_end = (src_col == coord_t'(`RESIZE_SRC_W - 1));

endmodule

// File: logic/resize_pkg.sv
`include "resize_params.svh"

package resize_pkg;

	// source or target coordinate
	typedef logic [`RESIZE_COORD_W-1:0] coord_t;

	// pixel on the input channel
	typedef struct packed {
		logic [`RESIZE_PIX_W-1:0] value;
		logic                     sof;
	} pix_in_t;

	// pixel on the output channel, flags refer to the resized frame
	typedef struct packed {
		logic [`RESIZE_PIX_W-1:0] value;
		logic                     sof;
		logic                     eol;
	} pix_out_t;

	// handshake FSM of the pixel gate
	typedef enum logic [1:0] {
		GATE_IDLE,
		GATE_OUT_REQ,
		GATE_OUT_REL,
		GATE_IN_ACK
	} gate_state_t;

endpackage

// File: logic/resize_params.svh
`ifndef RESIZE_PARAMS_SVH
`define RESIZE_PARAMS_SVH

// pixel value width, as delivered by the sensor interface
`define RESIZE_PIX_W 12

// source frame size
`define RESIZE_SRC_W 10
`define RESIZE_SRC_H 8

// resized frame size
`define RESIZE_DST_W 4
`define RESIZE_DST_H 3

// coordinate counters and target indices
`define RESIZE_COORD_W 12

// fixed point ratio, source over target, rounded up by one lsb
`define RESIZE_RATIO_FRAC 16
`define RESIZE_X_RATIO (((`RESIZE_SRC_W) << `RESIZE_RATIO_FRAC) / (`RESIZE_DST_W) + 1)
`define RESIZE_Y_RATIO (((`RESIZE_SRC_H) << `RESIZE_RATIO_FRAC) / (`RESIZE_DST_H) + 1)

`endif
